//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_evr_top
FILELIST  ?= evr_link.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/event_match.sv
`timescale 1ns/1ns

module event_match #(
    parameter logic SEL = evr_pkg::SEL_AFTER
) (
    input  logic                    app_clk,
    input  logic                    rst_n_i,
    input  logic                    cfg_we_i,
    input  logic                    cfg_sel_i,
    input  logic [evr_pkg::EV_W-1:0] cfg_code_i,
    input  logic [evr_pkg::EV_W-1:0] ev_i,
    output logic                    match_o
);

    import evr_pkg::*;

    logic [EV_W-1:0] code_q;
    logic            match_q;

    // Programmable event code, only writes addressed to this instance
    always_ff @(posedge app_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            code_q <= '0;
        end else if (cfg_we_i && (cfg_sel_i == SEL)) begin
            code_q <= cfg_code_i;
        end
    end

    // Code 0 means no event, so it never matches
    always_ff @(posedge app_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            match_q <= 1'b0;
        end else begin
            match_q <= (code_q != '0) && (ev_i == code_q);
        end
    end

    assign match_o = match_q;

    a_no_match_on_zero: assert property (
        @(posedge app_clk) disable iff (!rst_n_i)
        $rose(match_o) |-> ($past(code_q) != '0)
    );

endmodule

//--- design/evr_pkg.sv
package evr_pkg;

    // Lane widths
    localparam int unsigned EV_W   = 8;  // One event code or byte lane
    localparam int unsigned LINK_W = 16; // Data lane above event lane
    localparam int unsigned K_W    = 2;  // One K flag per lane

    // 8b/10b control symbols
    localparam logic [EV_W-1:0] K28_5       = 8'hBC; // Comma
    localparam logic [EV_W-1:0] K28_2_START = 8'h5C; // Segment frame start
    localparam logic [EV_W-1:0] K28_1_STOP  = 8'h3C; // Segment frame stop

    // Beacon event, sent when no comma is due
    localparam logic [EV_W-1:0] BEACON_CODE = 8'h7E;

    // Event lane cadence, in phase counts
    localparam int unsigned COMMA_PERIOD  = 4;
    localparam int unsigned BEACON_PERIOD = 7;

    // Segmented data buffer
    localparam int unsigned SEG_WORDS = 32;
    localparam int unsigned PHASE_W   = $clog2(2 * SEG_WORDS); // Data bytes on odd phases only

    // Matcher select values on the configuration port
    localparam logic SEL_AFTER  = 1'b0; // Compare against extracted event
    localparam logic SEL_BEFORE = 1'b1; // Compare against raw received byte

endpackage

//--- design/evr_top.sv
`timescale 1ns/1ns

module evr_top #(
    parameter int unsigned BLINK_HALF_CYCLES = 100000000
) (
    input  logic                      app_clk,
    input  logic                      rst_n_i,
    input  logic                      link_ready_i,
    input  logic [evr_pkg::LINK_W-1:0] rx_data_i,
    input  logic [evr_pkg::K_W-1:0]    rx_is_k_i,
    input  logic                      cfg_we_i,
    input  logic                      cfg_sel_i,
    input  logic [evr_pkg::EV_W-1:0]   cfg_code_i,
    output logic [evr_pkg::LINK_W-1:0] tx_data_o,
    output logic [evr_pkg::K_W-1:0]    tx_is_k_o,
    output logic                      after_dc_o,
    output logic                      before_dc_o,
    output logic [1:0]                led_o
);

    import evr_pkg::*;

    logic [EV_W-1:0] ev;         // Extracted event, one cycle behind rx
    logic            comma_seen;
    logic            heartbeat;

    frame_gen frame_gen_i (
        .app_clk      (app_clk),
        .rst_n_i      (rst_n_i),
        .link_ready_i (link_ready_i),
        .tx_data_o    (tx_data_o),
        .tx_is_k_o    (tx_is_k_o)
    );

    rx_event_decode rx_event_decode_i (
        .app_clk   (app_clk),
        .rst_n_i   (rst_n_i),
        .rx_data_i (rx_data_i),
        .rx_is_k_i (rx_is_k_i),
        .ev_o      (ev),
        .comma_o   (comma_seen)
    );

    // Fires two cycles after the rx word
    event_match #(
        .SEL (SEL_AFTER)
    ) match_after (
        .app_clk    (app_clk),
        .rst_n_i    (rst_n_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_sel_i  (cfg_sel_i),
        .cfg_code_i (cfg_code_i),
        .ev_i       (ev),
        .match_o    (after_dc_o)
    );

    // Raw event lane byte, K flags ignored
    event_match #(
        .SEL (SEL_BEFORE)
    ) match_before (
        .app_clk    (app_clk),
        .rst_n_i    (rst_n_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_sel_i  (cfg_sel_i),
        .cfg_code_i (cfg_code_i),
        .ev_i       (rx_data_i[EV_W-1:0]),
        .match_o    (before_dc_o)
    );

    led_blink #(
        .HALF_CYCLES (BLINK_HALF_CYCLES)
    ) led_blink_i (
        .app_clk (app_clk),
        .rst_n_i (rst_n_i),
        .led_o   (heartbeat)
    );

    assign led_o = {comma_seen, heartbeat};

endmodule

//--- design/frame_gen.sv
`timescale 1ns/1ns

module frame_gen (
    input  logic                      app_clk,
    input  logic                      rst_n_i,
    input  logic                      link_ready_i,
    output logic [evr_pkg::LINK_W-1:0] tx_data_o,
    output logic [evr_pkg::K_W-1:0]    tx_is_k_o
);

    import evr_pkg::*;

    localparam int unsigned IDX_W = $clog2(SEG_WORDS);

    logic [PHASE_W-1:0] phase_q;
    logic [IDX_W-1:0]   seg_idx;
    logic [EV_W-1:0]    ev_lane;
    logic [EV_W-1:0]    data_lane;
    logic [EV_W-1:0]    seg_byte;

    // Phase restarts whenever the link drops, wraps by overflow
    always_ff @(posedge app_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= '0;
        end else if (!link_ready_i) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // Segmented buffer frame, fixed contents
    always_comb begin
        case (seg_idx)
            5'd0:    seg_byte = K28_2_START;
            5'd1:    seg_byte = 8'hFF;        // Segment address
            5'd3:    seg_byte = 8'h8B;
            5'd4:    seg_byte = 8'hFC;
            5'd5:    seg_byte = 8'h7B;
            5'd9:    seg_byte = 8'h07;
            5'd17:   seg_byte = 8'h07;
            5'd18:   seg_byte = K28_1_STOP;
            5'd19:   seg_byte = 8'hFC;        // Checksum high
            5'd20:   seg_byte = 8'hF0;        // Checksum low
            default: seg_byte = 8'h00;
        endcase
    end

    assign seg_idx = phase_q[PHASE_W-1:1];

    // Event lane, comma takes priority over beacon
    always_comb begin
        ev_lane = '0;
        if (link_ready_i) begin
            if ((32'(phase_q) % COMMA_PERIOD) == 0) begin
                ev_lane = K28_5;
            end else if ((32'(phase_q) % BEACON_PERIOD) == 0) begin
                ev_lane = BEACON_CODE;
            end
        end
    end

    // Data lane carries buffer bytes on odd phases, distributed bus idle otherwise
    always_comb begin
        data_lane = '0;
        if (link_ready_i && phase_q[0]) begin
            data_lane = seg_byte;
        end
    end

    assign tx_data_o    = {data_lane, ev_lane};
    assign tx_is_k_o[0] = (ev_lane == K28_5);
    assign tx_is_k_o[1] = (data_lane == K28_2_START) || (data_lane == K28_1_STOP);

    // Idle link must not send control symbols
    a_no_k_when_idle: assert property (
        @(posedge app_clk) disable iff (!rst_n_i)
        !link_ready_i |-> (tx_is_k_o == '0)
    );

endmodule

//--- design/led_blink.sv
`timescale 1ns/1ns

module led_blink #(
    parameter int unsigned HALF_CYCLES = 100000000
) (
    input  logic app_clk,
    input  logic rst_n_i,
    output logic led_o
);

    localparam int unsigned CNT_W = $clog2(HALF_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             led_q;
    logic             wrap;

    assign wrap = (cnt_q == CNT_W'(HALF_CYCLES - 1)); // Last cycle of a half period

    always_ff @(posedge app_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            led_q <= 1'b0;
        end else if (wrap) begin
            cnt_q <= '0;
            led_q <= ~led_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign led_o = led_q;

    a_cnt_in_range: assert property (
        @(posedge app_clk) disable iff (!rst_n_i)
        32'(cnt_q) < HALF_CYCLES
    );

endmodule

//--- design/rx_event_decode.sv
`timescale 1ns/1ns

module rx_event_decode (
    input  logic                      app_clk,
    input  logic                      rst_n_i,
    input  logic [evr_pkg::LINK_W-1:0] rx_data_i,
    input  logic [evr_pkg::K_W-1:0]    rx_is_k_i,
    output logic [evr_pkg::EV_W-1:0]   ev_o,
    output logic                      comma_o
);

    import evr_pkg::*;

    logic [EV_W-1:0] ev_q;
    logic            comma_q;

    always_ff @(posedge app_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ev_q    <= '0;
            comma_q <= 1'b0;
        end else begin
            // K characters on the event lane are framing, not events
            ev_q    <= rx_is_k_i[0] ? '0 : rx_data_i[EV_W-1:0];
            comma_q <= |rx_is_k_i; // Any lane
        end
    end

    assign ev_o    = ev_q;
    assign comma_o = comma_q;

    // A received K symbol never shows up as an event code
    a_k_rejected: assert property (
        @(posedge app_clk) disable iff (!rst_n_i)
        rx_is_k_i[0] |=> (ev_o == '0)
    );

endmodule

//--- evr_link.f
design/evr_pkg.sv
design/frame_gen.sv
design/rx_event_decode.sv
design/event_match.sv
design/led_blink.sv
design/evr_top.sv
test/tb_evr_top.sv

//--- test/evr_trace.txt
# link_ready rx_data rx_is_k cfg_we cfg_sel cfg_code exp_before_dc exp_after_dc, all hex
# Expected outputs are the values seen in the cycle in which the line is driven
1 0000 0 0 0 00 0 0
1 1200 0 0 0 00 0 0
1 0025 0 0 0 00 0 0
1 0000 0 1 0 25 0 0
1 3425 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 1
1 0025 1 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 AB25 2 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 1
1 00BC 1 1 1 BC 0 0
1 00BC 1 0 0 00 0 0
1 0000 0 0 0 00 1 0
1 0025 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 1
1 00BC 0 1 0 7E 0 0
1 007E 0 0 0 00 1 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 1
0 0000 3 0 0 00 0 0
0 0000 0 0 0 00 0 0
0 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 00BC 0 0 0 00 0 0
1 00BC 0 1 1 00 1 0
1 00BC 0 0 0 00 1 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 1 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 1 0 91 0 0
1 0000 0 1 1 91 0 0
1 5591 0 0 0 00 0 0
1 0091 1 0 0 00 1 0
1 0091 0 0 0 00 1 1
1 0000 0 0 0 00 1 0
1 0000 0 0 0 00 0 1
1 0000 0 0 0 00 0 0
1 9100 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 2 0 0 00 0 0
1 0000 0 0 0 00 0 0
1 0000 0 0 0 00 0 0

//--- test/tb_evr_top.sv
`timescale 1ns/1ns

module tb_evr_top;

    localparam int unsigned HALF_PERIOD  = 50;  // 100 ns clock
    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned BLINK_HALF   = 16;
    localparam int unsigned RANDOM_WORDS = 200;
    localparam int unsigned LED_TIMEOUT  = 40;
    localparam int unsigned FRAME_CYCLES = 130; // Two full phase wraps

    // Link symbols
    localparam logic [7:0] COMMA      = 8'hBC;
    localparam logic [7:0] START_MARK = 8'h5C;
    localparam logic [7:0] STOP_MARK  = 8'h3C;
    localparam logic [7:0] BEACON     = 8'h7E;

    logic        app_clk;
    logic        rst_n_i;
    logic        link_ready;
    logic [15:0] rx_data;
    logic [1:0]  rx_is_k;
    logic        cfg_we;
    logic        cfg_sel;
    logic [7:0]  cfg_code;
    logic [15:0] tx_data;
    logic [1:0]  tx_is_k;
    logic        after_dc;
    logic        before_dc;
    logic [1:0]  led;

    // Reference model state
    logic [7:0]  seg_table [32];
    int unsigned phase_m;
    int unsigned hb_cnt;         // Cycles since reset release
    logic [7:0]  code_after_m;
    logic [7:0]  code_before_m;
    logic [7:0]  ev_m;
    logic        comma_m;
    logic        after_m;
    logic        before_m;
    logic        rst_next;       // Reset level driven at the next edge
    logic [31:0] rand_state;

    evr_top #(
        .BLINK_HALF_CYCLES (BLINK_HALF)
    ) dut0 (
        .app_clk      (app_clk),
        .rst_n_i      (rst_n_i),
        .link_ready_i (link_ready),
        .rx_data_i    (rx_data),
        .rx_is_k_i    (rx_is_k),
        .cfg_we_i     (cfg_we),
        .cfg_sel_i    (cfg_sel),
        .cfg_code_i   (cfg_code),
        .tx_data_o    (tx_data),
        .tx_is_k_o    (tx_is_k),
        .after_dc_o   (after_dc),
        .before_dc_o  (before_dc),
        .led_o        (led)
    );

    initial app_clk = 1'b0;
    always #HALF_PERIOD app_clk = ~app_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Segment buffer frame as the link spec lists it
    task automatic load_frame_table();
        logic [7:0] body [16];
        body = '{8'h00, 8'h8B, 8'hFC, 8'h7B, 8'h00, 8'h00, 8'h00, 8'h07,
                 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h07};
        for (int i = 0; i < 32; i++) begin
            seg_table[i] = 8'h00;
        end
        seg_table[0] = START_MARK;
        seg_table[1] = 8'hFF;
        for (int i = 0; i < 16; i++) begin
            seg_table[i + 2] = body[i];
        end
        seg_table[18] = STOP_MARK;
        seg_table[19] = 8'hFC;
        seg_table[20] = 8'hF0;
    endtask

    // {k flags, data lane, event lane} for one phase
    function automatic logic [17:0] frame_word(input int unsigned phase, input logic lr);
        logic [7:0] ev;
        logic [7:0] data;
        ev   = 8'h00;
        data = 8'h00;
        if (lr) begin
            if (phase % 4 == 0) begin
                ev = COMMA;
            end else if (phase % 7 == 0) begin
                ev = BEACON;
            end
            if (phase % 2 == 1) begin
                data = seg_table[phase / 2];
            end
        end
        return {(data == START_MARK) || (data == STOP_MARK), ev == COMMA, data, ev};
    endfunction

    // Called right after the edge, so inputs still hold what the DUT sampled
    task automatic advance_model();
        logic [7:0] raw;
        logic       hit_before;
        logic       hit_after;
        raw = rx_data[7:0];
        if (!rst_n_i) begin
            phase_m       = 0;
            hb_cnt        = 0;
            code_after_m  = 8'h00;
            code_before_m = 8'h00;
            ev_m          = 8'h00;
            comma_m       = 1'b0;
            after_m       = 1'b0;
            before_m      = 1'b0;
        end else begin
            hit_before = (code_before_m != 8'h00) && (raw == code_before_m);
            hit_after  = (code_after_m != 8'h00) && (ev_m == code_after_m);
            before_m   = hit_before;
            after_m    = hit_after;
            ev_m       = rx_is_k[0] ? 8'h00 : raw;
            comma_m    = |rx_is_k;
            if (cfg_we && cfg_sel) begin
                code_before_m = cfg_code;
            end
            if (cfg_we && !cfg_sel) begin
                code_after_m = cfg_code;
            end
            phase_m = link_ready ? (phase_m + 1) % 64 : 0;
            hb_cnt++;
        end
    endtask

    // One clock: drive at the rising edge, check mid-cycle
    task automatic step_cycle(input logic lr, input logic [15:0] rxd, input logic [1:0] rxk,
                              input logic we, input logic sel, input logic [7:0] code);
        logic [17:0] exp_tx;
        @(posedge app_clk);
        advance_model();
        rst_n_i    <= rst_next;
        link_ready <= lr;
        rx_data    <= rxd;
        rx_is_k    <= rxk;
        cfg_we     <= we;
        cfg_sel    <= sel;
        cfg_code   <= code;
        @(negedge app_clk);
        exp_tx = frame_word(phase_m, link_ready);
        check_value(32'(tx_data), 32'(exp_tx[15:0]), "tx_data_o");
        check_value(32'(tx_is_k), 32'(exp_tx[17:16]), "tx_is_k_o");
        check_value(32'(led[0]), (hb_cnt / BLINK_HALF) % 2, "led_o[0] heartbeat");
        check_value(32'(led[1]), 32'(comma_m), "led_o[1] comma seen");
    endtask

    task automatic step_idle();
        step_cycle(1'b0, 16'h0000, 2'b00, 1'b0, 1'b0, 8'h00);
    endtask

    task automatic check_quiet_outputs(input string when);
        check_value(32'(after_dc), 32'd0, {"after_dc_o ", when});
        check_value(32'(before_dc), 32'd0, {"before_dc_o ", when});
        check_value(32'(led), 32'd0, {"led_o ", when});
    endtask

    task automatic run_trace();
        int          fd;
        int          rc;
        int          fields;
        int          line_no;
        int          data_lines;
        string       line;
        logic [31:0] lr;
        logic [31:0] rxd;
        logic [31:0] rxk;
        logic [31:0] we;
        logic [31:0] sel;
        logic [31:0] code;
        logic [31:0] exp_b;
        logic [31:0] exp_a;
        line_no    = 0;
        data_lines = 0;
        fd = $fopen("test/evr_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file test/evr_trace.txt");
            $display("Test failed");
            $fatal(1, "Missing trace file");
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0) begin
                break;
            end
            line_no++;
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;   // Header or blank line
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                             lr, rxd, rxk, we, sel, code, exp_b, exp_a);
            if (fields != 8) begin
                $display("Trace line %0d holds %0d fields instead of 8", line_no, fields);
                $display("Test failed");
                $fatal(1, "Malformed trace");
            end
            step_cycle(lr[0], rxd[15:0], rxk[1:0], we[0], sel[0], code[7:0]);
            check_value(32'(before_dc), exp_b, $sformatf("before_dc_o, trace line %0d", line_no));
            check_value(32'(after_dc), exp_a, $sformatf("after_dc_o, trace line %0d", line_no));
            data_lines++;
        end
        $fclose(fd);
        if (data_lines == 0) begin
            $display("The trace file holds no stimulus lines");
            $display("Test failed");
            $fatal(1, "Empty trace");
        end
    endtask

    // Link restarted and held up long enough to reach the stop marker and the phase wrap
    task automatic run_full_frames();
        step_idle();
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            step_cycle(1'b1, 16'h0000, 2'b00, 1'b0, 1'b0, 8'h00);
            check_value(32'(before_dc), 32'(before_m), $sformatf("before_dc_o, frame cycle %0d", n));
            check_value(32'(after_dc), 32'(after_m), $sformatf("after_dc_o, frame cycle %0d", n));
        end
    endtask

    // Random rx words, biased towards the programmed codes
    task automatic run_random();
        logic [31:0] r;
        logic [7:0]  lo;
        logic [1:0]  k;
        for (int n = 0; n < RANDOM_WORDS; n++) begin
            rand_state = lcg_next(rand_state);
            r = rand_state;
            case (r[17:16])
                2'd0:    lo = code_after_m;
                2'd1:    lo = code_before_m;
                default: lo = r[15:8];
            endcase
            k = (r[22:20] == 3'd0) ? r[19:18] : 2'b00;
            step_cycle(r[27:24] != 4'h0, {r[7:0], lo}, k, r[30:28] == 3'd7, r[23],
                       r[31] ? r[15:8] : 8'h00);
            check_value(32'(before_dc), 32'(before_m), $sformatf("before_dc_o, random word %0d", n));
            check_value(32'(after_dc), 32'(after_m), $sformatf("after_dc_o, random word %0d", n));
        end
    endtask

    initial begin
        int waited;
        rst_n_i       = 1'b0;
        rst_next      = 1'b0;
        link_ready    = 1'b0;
        rx_data       = 16'h0000;
        rx_is_k       = 2'b00;
        cfg_we        = 1'b0;
        cfg_sel       = 1'b0;
        cfg_code      = 8'h00;
        phase_m       = 0;
        hb_cnt        = 0;
        code_after_m  = 8'h00;
        code_before_m = 8'h00;
        ev_m          = 8'h00;
        comma_m       = 1'b0;
        after_m       = 1'b0;
        before_m      = 1'b0;
        rand_state    = 32'hb1d4_2468;
        load_frame_table();

        // Release is driven at the last reset edge
        for (int c = 1; c <= RESET_CYCLES; c++) begin
            rst_next = (c == RESET_CYCLES);
            step_idle();
            check_quiet_outputs("during reset");
        end
        step_idle();
        check_quiet_outputs("in the first cycle after reset");

        waited = 0;
        while (led[0] !== 1'b1) begin
            if (waited >= LED_TIMEOUT) begin
                $display("Timed out waiting for the first heartbeat toggle");
                $display("Test failed");
                $fatal(1, "Heartbeat never toggled");
            end
            step_idle();
            waited++;
        end
        check_value(hb_cnt, BLINK_HALF, "cycles from reset release to first heartbeat toggle");

        run_trace();
        run_full_frames();
        run_random();

        $display("Test completed successfully");
        $finish;
    end

endmodule
